//--- pcore_macros.svh
`ifndef PCORE_MACROS_SVH
`define PCORE_MACROS_SVH

// Data and address width
`define XLEN 32

// First fetch address out of reset
`define PC_RESET 32'h0000_0100

// addi x0, x0, 0
`define INSTR_NOP 32'h0000_0013

// Instruction TLB size
`define ITLB_ENTRIES 4

// Line buffer geometry and miss penalty
`define LINE_WORDS 4
`define FILL_CYCLES 3

// Instruction memory depth in words
`define IMEM_WORDS 256

`endif

//--- pcore_pkg.sv
`include "pcore_macros.svh"

package pcore_pkg;

    // Misaligned fetch keeps the RISC-V cause value
    typedef enum logic [3:0] {
        EXC_CODE_INSTR_MISALIGN = 4'd0,
        EXC_CODE_NO_EXCEPTION   = 4'd10   // Reserved cause, never raised
    } type_exc_code_e;

    // Fetch to TLB
    typedef struct packed {
        logic [`XLEN-1:0] i_vaddr;
        logic             i_req;
    } type_if2mmu_s;

    // TLB to fetch
    typedef struct packed {
        logic [`XLEN-1:0] i_paddr;
        logic             i_hit;
    } type_mmu2if_s;

    // Fetch to instruction memory
    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic             req;
    } type_if2icache_s;

    // Instruction memory to fetch
    typedef struct packed {
        logic [`XLEN-1:0] r_data;
        logic             ack;
    } type_icache2if_s;

    // Fetch to decode, payload
    typedef struct packed {
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] pc_next;
        logic             instr_valid;
    } type_if2id_data_s;

    // Fetch to decode, exceptions
    typedef struct packed {
        type_exc_code_e exc_code;
        logic           exc_req;
    } type_if2id_ctrl_s;

    // Branch and jump redirect from execute
    typedef struct packed {
        logic [`XLEN-1:0] pc_new;
        logic             new_pc_req;
    } type_exe2if_fb_s;

    // Trap, return and WFI from CSR unit
    typedef struct packed {
        logic [`XLEN-1:0] pc_new;
        logic             new_pc_req;
        logic             wfi_req;
    } type_csr2if_fb_s;

    // Merged fetch control
    typedef struct packed {
        logic csr_new_pc_req;
        logic wfi_req;
        logic exe_new_pc_req;
        logic if_stall;
    } type_fwd2if_s;

    // One TLB entry write
    typedef struct packed {
        logic [19:0]                       vpn;
        logic [19:0]                       ppn;
        logic [$clog2(`ITLB_ENTRIES)-1:0]  idx;
        logic                              valid;
        logic                              strobe;
    } type_tlb_fill_s;

endpackage : pcore_pkg

//--- fetch.sv
`timescale 1ns/1ps
`include "pcore_macros.svh"

module fetch (
    input  logic                         clk,
    input  logic                         rst_n,

    // Instruction memory side
    output pcore_pkg::type_if2icache_s   if2icache_o,
    input  pcore_pkg::type_icache2if_s   icache2if_i,

    // TLB side
    output pcore_pkg::type_if2mmu_s      if2mmu_o,
    input  pcore_pkg::type_mmu2if_s      mmu2if_i,

    // Decode side
    output pcore_pkg::type_if2id_data_s  if2id_data_o,
    output pcore_pkg::type_if2id_ctrl_s  if2id_ctrl_o,

    // Redirect feedback
    input  pcore_pkg::type_exe2if_fb_s   exe2if_fb_i,
    input  pcore_pkg::type_csr2if_fb_s   csr2if_fb_i,

    // Forward/stall unit
    input  pcore_pkg::type_fwd2if_s      fwd2if_i,
    output logic                         if2fwd_stall_o
);

    logic [`XLEN-1:0]          pc_ff;          // Address of the word on the decode side
    logic [`XLEN-1:0]          pc_next;        // Address requested this cycle
    logic                      req_en_ff;      // Fetch enabled once out of reset
    logic                      if_stall;
    logic                      pc_misaligned;
    pcore_pkg::type_exc_code_e exc_code;
    logic                      exc_req;

    // Memory not ready or pipeline held
    assign if_stall      = fwd2if_i.if_stall | ~icache2if_i.ack;
    assign pc_misaligned = pc_ff[1] | pc_ff[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_ff     <= `PC_RESET;
            req_en_ff <= 1'b0;
        end else begin
            pc_ff     <= pc_next;
            req_en_ff <= 1'b1;
        end
    end

    // Fixed priority, CSR wins over everything
    always_comb begin
        pc_next = pc_ff + `XLEN'(4);

        case (1'b1)
            fwd2if_i.csr_new_pc_req: begin
                pc_next = csr2if_fb_i.pc_new;
            end
            fwd2if_i.wfi_req: begin
                pc_next = pc_ff;               // Sleep until woken
            end
            fwd2if_i.exe_new_pc_req: begin
                pc_next = exe2if_fb_i.pc_new;
            end
            if_stall: begin
                pc_next = pc_ff;               // Same address asked again
            end
            default: begin
                pc_next = pc_ff + `XLEN'(4);
            end
        endcase
    end

    always_comb begin
        exc_req  = 1'b0;
        exc_code = pcore_pkg::EXC_CODE_NO_EXCEPTION;

        if (pc_misaligned) begin
            exc_req  = 1'b1;
            exc_code = pcore_pkg::EXC_CODE_INSTR_MISALIGN;
        end
    end

    // Translation request, then physical address on to memory
    assign if2mmu_o.i_vaddr = pc_next;
    assign if2mmu_o.i_req   = req_en_ff;
    assign if2icache_o.addr = mmu2if_i.i_paddr;
    assign if2icache_o.req  = mmu2if_i.i_hit;   // No request on a TLB miss

    // Word for pc_ff arrives with ack
    assign if2id_data_o.instr       = icache2if_i.ack ? icache2if_i.r_data : `INSTR_NOP;
    assign if2id_data_o.pc          = pc_ff;
    assign if2id_data_o.pc_next     = pc_next;
    assign if2id_data_o.instr_valid = icache2if_i.ack;

    assign if2id_ctrl_o.exc_code = exc_code;
    assign if2id_ctrl_o.exc_req  = exc_req;

    assign if2fwd_stall_o = if2mmu_o.i_req & ~icache2if_i.ack;

    // Held PC must survive until a redirect shows up
    assert property (@(posedge clk) disable iff (!rst_n)
        (fwd2if_i.if_stall && !fwd2if_i.csr_new_pc_req && !fwd2if_i.exe_new_pc_req)
        |=> (pc_ff == $past(pc_ff)))
        else $error("fetch: PC moved during stall");

endmodule : fetch

//--- itlb.sv
`timescale 1ns/1ps
`include "pcore_macros.svh"

module itlb (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       translate_en_i,  // Off means bare mode
    input  pcore_pkg::type_tlb_fill_s  tlb_fill_i,
    input  pcore_pkg::type_if2mmu_s    if2mmu_i,
    output pcore_pkg::type_mmu2if_s    mmu2if_o
);

    localparam int VPN_W = 20;
    localparam int OFF_W = `XLEN - VPN_W;   // 4 KiB pages

    logic [VPN_W-1:0]         vpn_ff [`ITLB_ENTRIES];
    logic [VPN_W-1:0]         ppn_ff [`ITLB_ENTRIES];
    logic [`ITLB_ENTRIES-1:0] valid_ff;
    logic [`ITLB_ENTRIES-1:0] match;
    logic [VPN_W-1:0]         vpn;
    logic [VPN_W-1:0]         ppn_sel;

    assign vpn = if2mmu_i.i_vaddr[`XLEN-1:OFF_W];

    // Valid bits only, entry contents need no reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_ff <= '0;
        end else if (tlb_fill_i.strobe) begin
            valid_ff[tlb_fill_i.idx] <= tlb_fill_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_fill_i.strobe) begin
            vpn_ff[tlb_fill_i.idx] <= tlb_fill_i.vpn;
            ppn_ff[tlb_fill_i.idx] <= tlb_fill_i.ppn;
        end
    end

    // Fully associative compare
    always_comb begin
        ppn_sel = '0;
        for (int i = 0; i < `ITLB_ENTRIES; i++) begin
            match[i] = valid_ff[i] & (vpn_ff[i] == vpn);
            if (match[i]) begin
                ppn_sel = ppn_ff[i];
            end
        end
    end

    always_comb begin
        if (translate_en_i) begin
            mmu2if_o.i_paddr = {ppn_sel, if2mmu_i.i_vaddr[OFF_W-1:0]};
            mmu2if_o.i_hit   = if2mmu_i.i_req & (|match);
        end else begin
            mmu2if_o.i_paddr = if2mmu_i.i_vaddr;   // Identity map
            mmu2if_o.i_hit   = if2mmu_i.i_req;
        end
    end

    // Fills over time must never leave a duplicate mapping
    assert property (@(posedge clk) disable iff (!rst_n)
        (translate_en_i && if2mmu_i.i_req) |-> $onehot0(match))
        else $error("itlb: several entries map one VPN");

endmodule : itlb

//--- imem_line_buf.sv
`timescale 1ns/1ps
`include "pcore_macros.svh"

module imem_line_buf (
    input  logic                                clk,
    input  logic                                rst_n,
    input  pcore_pkg::type_if2icache_s          if2icache_i,
    output pcore_pkg::type_icache2if_s          icache2if_o,
    input  logic                                we_i,
    input  logic [$clog2(`IMEM_WORDS)-1:0]      waddr_i,  // Word index
    input  logic [`XLEN-1:0]                    wdata_i
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);
    localparam int OFF_W = $clog2(`LINE_WORDS);
    localparam int TAG_W = `XLEN - OFF_W - 2;
    localparam int CNT_W = $clog2(`FILL_CYCLES + 1);

    logic [`XLEN-1:0] mem [`IMEM_WORDS];
    logic [`XLEN-1:0] line_buf [`LINE_WORDS];
    logic [`XLEN-1:0] addr_ff;        // Request from the previous cycle
    logic             req_ff;
    logic [TAG_W-1:0] line_tag_ff;
    logic             line_valid_ff;
    logic [TAG_W-1:0] fill_tag_ff;    // Line the counter is loading
    logic [CNT_W-1:0] fill_cnt_ff;
    logic [TAG_W-1:0] cur_tag;
    logic             hit;
    logic             miss;
    logic             restart;
    logic             load;

    assign cur_tag = addr_ff[`XLEN-1:OFF_W+2];
    assign hit     = line_valid_ff & (line_tag_ff == cur_tag);
    assign miss    = req_ff & ~hit;
    // New miss, or the address moved to another line mid-fill
    assign restart = miss & ((fill_cnt_ff == '0) | (fill_tag_ff != cur_tag));
    assign load    = miss & ~restart & ~we_i & (fill_cnt_ff == CNT_W'(`FILL_CYCLES - 1));

    assign icache2if_o.ack    = req_ff & hit;
    assign icache2if_o.r_data = line_buf[addr_ff[OFF_W+1:2]];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        addr_ff <= if2icache_i.addr;
        if (restart) begin
            fill_tag_ff <= cur_tag;
        end
        if (load) begin
            line_tag_ff <= cur_tag;
            for (int w = 0; w < `LINE_WORDS; w++) begin
                line_buf[w] <= mem[{addr_ff[IDX_W+1:OFF_W+2], OFF_W'(w)}];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_ff        <= 1'b0;
            line_valid_ff <= 1'b0;
            fill_cnt_ff   <= '0;
        end else begin
            req_ff <= if2icache_i.req;
            if (we_i) begin
                line_valid_ff <= 1'b0;     // Buffer may hold stale code
                fill_cnt_ff   <= '0;
            end else if (load) begin
                line_valid_ff <= 1'b1;
                fill_cnt_ff   <= '0;
            end else if (restart) begin
                fill_cnt_ff <= CNT_W'(1);
            end else if (miss) begin
                fill_cnt_ff <= fill_cnt_ff + CNT_W'(1);
            end else begin
                fill_cnt_ff <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !$past(if2icache_i.req) |-> !icache2if_o.ack)
        else $error("imem_line_buf: ack without a request");

endmodule : imem_line_buf

//--- fwd_stall.sv
`timescale 1ns/1ps

module fwd_stall (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        id_stall_i,       // Decode back-pressure
    input  pcore_pkg::type_exe2if_fb_s  exe2if_fb_i,
    input  pcore_pkg::type_csr2if_fb_s  csr2if_fb_i,
    input  logic                        if2fwd_stall_i,   // Fetch waits on memory
    output pcore_pkg::type_fwd2if_s     fwd2if_o,
    output logic                        stall_o
);

    logic wfi_ff;

    // CSR redirect doubles as the interrupt wake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wfi_ff <= 1'b0;
        end else if (csr2if_fb_i.new_pc_req) begin
            wfi_ff <= 1'b0;
        end else if (csr2if_fb_i.wfi_req) begin
            wfi_ff <= 1'b1;
        end
    end

    assign fwd2if_o.csr_new_pc_req = csr2if_fb_i.new_pc_req;
    assign fwd2if_o.wfi_req        = wfi_ff;
    assign fwd2if_o.exe_new_pc_req = exe2if_fb_i.new_pc_req & ~wfi_ff;  // Ignored while asleep
    assign fwd2if_o.if_stall       = id_stall_i | wfi_ff;

    // Memory wait reported outward only
    assign stall_o = if2fwd_stall_i;

endmodule : fwd_stall

//--- if_top.sv
`timescale 1ns/1ps
`include "pcore_macros.svh"

module if_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              translate_en_i,
    input  pcore_pkg::type_tlb_fill_s         tlb_fill_i,
    input  logic                              imem_we_i,
    input  logic [$clog2(`IMEM_WORDS)-1:0]    imem_waddr_i,
    input  logic [`XLEN-1:0]                  imem_wdata_i,
    input  logic                              id_stall_i,
    input  pcore_pkg::type_exe2if_fb_s        exe2if_fb_i,
    input  pcore_pkg::type_csr2if_fb_s        csr2if_fb_i,
    output pcore_pkg::type_if2id_data_s       if2id_data_o,
    output pcore_pkg::type_if2id_ctrl_s       if2id_ctrl_o,
    output logic                              stall_o
);

    pcore_pkg::type_if2mmu_s    if2mmu;
    pcore_pkg::type_mmu2if_s    mmu2if;
    pcore_pkg::type_if2icache_s if2icache;
    pcore_pkg::type_icache2if_s icache2if;
    pcore_pkg::type_fwd2if_s    fwd2if;
    logic                       if2fwd_stall;

    fetch u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .if2icache_o    (if2icache),
        .icache2if_i    (icache2if),
        .if2mmu_o       (if2mmu),
        .mmu2if_i       (mmu2if),
        .if2id_data_o   (if2id_data_o),
        .if2id_ctrl_o   (if2id_ctrl_o),
        .exe2if_fb_i    (exe2if_fb_i),
        .csr2if_fb_i    (csr2if_fb_i),
        .fwd2if_i       (fwd2if),
        .if2fwd_stall_o (if2fwd_stall)
    );

    itlb u_itlb (
        .clk            (clk),
        .rst_n          (rst_n),
        .translate_en_i (translate_en_i),
        .tlb_fill_i     (tlb_fill_i),
        .if2mmu_i       (if2mmu),
        .mmu2if_o       (mmu2if)
    );

    imem_line_buf u_imem_line_buf (
        .clk            (clk),
        .rst_n          (rst_n),
        .if2icache_i    (if2icache),
        .icache2if_o    (icache2if),
        .we_i           (imem_we_i),
        .waddr_i        (imem_waddr_i),
        .wdata_i        (imem_wdata_i)
    );

    fwd_stall u_fwd_stall (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_stall_i     (id_stall_i),
        .exe2if_fb_i    (exe2if_fb_i),
        .csr2if_fb_i    (csr2if_fb_i),
        .if2fwd_stall_i (if2fwd_stall),
        .fwd2if_o       (fwd2if),
        .stall_o        (stall_o)
    );

endmodule : if_top

//--- tb_if_tests.svh
`ifndef TB_IF_TESTS_SVH
`define TB_IF_TESTS_SVH

    // Returns in the first cycle, this one included, that carries a word
    task automatic wait_valid();
        while (!id_data.instr_valid) begin
            cycle();
        end
    endtask

    task automatic check_word(input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] paddr);
        check(id_data.pc == pc, $sformatf("pc %h, expected %h", id_data.pc, pc));
        check(id_data.instr == word_at(paddr),
              $sformatf("pc %h: instr %h, expected %h", pc, id_data.instr, word_at(paddr)));
    endtask

    task automatic redirect_exe(input logic [`XLEN-1:0] target);
        exe_fb.pc_new     = target;
        exe_fb.new_pc_req = 1'b1;
        cycle();
        exe_fb = '0;
        check(id_data.pc == target, $sformatf("after redirect pc %h, expected %h",
              id_data.pc, target));
    endtask

    task automatic sequential_fetch();
        logic [`XLEN-1:0] exp_pc;
        exp_pc = `PC_RESET;
        for (int n = 0; n < 12; n++) begin
            wait_valid();
            check_word(exp_pc, exp_pc);
            // Nothing holds fetch, so the next PC is the sequential one
            check(id_data.pc_next == exp_pc + 4,
                  $sformatf("pc %h: pc_next %h, expected %h",
                            exp_pc, id_data.pc_next, exp_pc + 4));
            last_pc = exp_pc;
            exp_pc  = exp_pc + 4;
            cycle();
        end
    endtask

    // Miss costs FILL_CYCLES empty cycles, then a held PC refetches from the buffer
    task automatic line_crossing();
        int               gap;
        logic             seen_stall;
        logic [`XLEN-1:0] exp_pc;
        exp_pc = last_pc + 4;
        for (int n = 0; n < 10; n++) begin
            gap        = 0;
            seen_stall = 1'b0;
            while (!id_data.instr_valid) begin
                gap++;
                seen_stall |= stall;
                cycle();
            end
            check_word(exp_pc, exp_pc);
            if (((exp_pc >> 2) % `LINE_WORDS) == 0) begin
                check(gap == `FILL_CYCLES && seen_stall,
                      $sformatf("line start %h: gap %0d, stall seen %0b", exp_pc, gap, seen_stall));
            end else begin
                check(gap == 0, $sformatf("pc %h inside a line waited %0d cycles", exp_pc, gap));
            end
            exp_pc = exp_pc + 4;
            cycle();
        end
        wait_valid();
        check_word(exp_pc, exp_pc);
        last_pc  = exp_pc;
        id_stall = 1'b1;
        for (int n = 0; n < 4; n++) begin
            cycle();
            check(id_data.instr_valid, "no word while decode stalls");
            check_word(last_pc, last_pc);
        end
        id_stall = 1'b0;
        cycle();
        wait_valid();
        check_word(last_pc + 4, last_pc + 4);
    endtask

    task automatic redirect_priority();
        redirect_exe(32'h0000_0248);
        wait_valid();
        check_word(32'h0000_0248, 32'h0000_0248);
        cycle();
        exe_fb.pc_new     = 32'h0000_0200;
        exe_fb.new_pc_req = 1'b1;
        csr_fb.pc_new     = 32'h0000_0380;  // CSR target wins
        csr_fb.new_pc_req = 1'b1;
        cycle();
        exe_fb = '0;
        csr_fb = '0;
        wait_valid();
        check_word(32'h0000_0380, 32'h0000_0380);
    endtask

    task automatic wfi_sleep_wake();
        logic [`XLEN-1:0] held_pc;
        cycle();
        check_word(32'h0000_0384, 32'h0000_0384);
        csr_fb.wfi_req = 1'b1;
        cycle();
        csr_fb  = '0;
        held_pc = 32'h0000_0388;           // Strobe cycle still advances once
        for (int n = 0; n < 12; n++) begin
            exe_fb.pc_new     = 32'h0000_0200;
            exe_fb.new_pc_req = (n == 4);  // Must be ignored while asleep
            cycle();
            check(id_data.pc == held_pc, $sformatf("pc %h moved during WFI, held %h",
                  id_data.pc, held_pc));
        end
        exe_fb            = '0;
        csr_fb.pc_new     = 32'h0000_01c0;
        csr_fb.new_pc_req = 1'b1;
        cycle();
        csr_fb = '0;
        wait_valid();
        check_word(32'h0000_01c0, 32'h0000_01c0);
    endtask

    task automatic misaligned_target();
        check(!id_ctrl.exc_req, "exception raised on an aligned pc");
        redirect_exe(32'h0000_0106);
        check(id_ctrl.exc_req && id_ctrl.exc_code == pcore_pkg::EXC_CODE_INSTR_MISALIGN,
              $sformatf("pc 106: exc_req %0b, code %0d", id_ctrl.exc_req, id_ctrl.exc_code));
        redirect_exe(32'h0000_0100);
        check(!id_ctrl.exc_req, "exception still set after an aligned redirect");
    endtask

    // VPN 5 mapped to PPN 2 through entry 1
    task automatic tlb_translation();
        logic [`XLEN-1:0] vaddr;
        logic [`XLEN-1:0] paddr;
        vaddr = 32'h0000_5040;
        paddr = {20'h00002, vaddr[11:0]};
        cycle();
        translate_en = 1'b1;
        redirect_exe(vaddr);
        for (int n = 0; n < 10; n++) begin
            check(!id_data.instr_valid, "valid word without a TLB entry");
            cycle();
        end
        tlb_fill.vpn    = vaddr[31:12];
        tlb_fill.ppn    = paddr[31:12];
        tlb_fill.idx    = 2'd1;
        tlb_fill.valid  = 1'b1;
        tlb_fill.strobe = 1'b1;
        cycle();
        tlb_fill = '0;
        wait_valid();
        check_word(vaddr, paddr);
        cycle();
        wait_valid();
        check_word(vaddr + 4, paddr + 4);
    endtask

`endif

//--- tb_if_top.sv
`timescale 1ns/1ps
`include "pcore_macros.svh"

module tb_if_top;

    localparam int AW         = $clog2(`IMEM_WORDS);
    localparam int MAX_CYCLES = 2000;   // Load plus tests come to about 400 cycles
    localparam int SEED       = 59558;

    logic                         clk;
    logic                         rst_n;
    logic                         translate_en;
    pcore_pkg::type_tlb_fill_s    tlb_fill;
    logic                         imem_we;
    logic [AW-1:0]                imem_waddr;
    logic [`XLEN-1:0]             imem_wdata;
    logic                         id_stall;
    pcore_pkg::type_exe2if_fb_s   exe_fb;
    pcore_pkg::type_csr2if_fb_s   csr_fb;
    pcore_pkg::type_if2id_data_s  id_data;
    pcore_pkg::type_if2id_ctrl_s  id_ctrl;
    logic                         stall;

    logic [`XLEN-1:0] mem_model [`IMEM_WORDS];  // Copy of every word written
    logic [`XLEN-1:0] rng_state;
    logic [`XLEN-1:0] last_pc;                   // Latest valid PC seen
    int               cycle_cnt;
    int               err_cnt;

    if_top u_if_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .translate_en_i (translate_en),
        .tlb_fill_i     (tlb_fill),
        .imem_we_i      (imem_we),
        .imem_waddr_i   (imem_waddr),
        .imem_wdata_i   (imem_wdata),
        .id_stall_i     (id_stall),
        .exe2if_fb_i    (exe_fb),
        .csr2if_fb_i    (csr_fb),
        .if2id_data_o   (id_data),
        .if2id_ctrl_o   (id_ctrl),
        .stall_o        (stall)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    function automatic logic [`XLEN-1:0] xorshift32(input logic [`XLEN-1:0] x);
        logic [`XLEN-1:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word at a physical byte address, memory wraps every IMEM_WORDS words
    function automatic logic [`XLEN-1:0] word_at(input logic [`XLEN-1:0] paddr);
        return mem_model[paddr[AW+1:2]];
    endfunction

    task automatic cycle();
        @(negedge clk);
    endtask

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            err_cnt++;
            $display("FAIL @%0t: %s", $time, msg);
            $display("Verification failed");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    // Random program image, also kept in mem_model
    task automatic load_memory();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            rng_state    = xorshift32(rng_state);
            mem_model[i] = rng_state;
            imem_we      = 1'b1;
            imem_waddr   = AW'(i);
            imem_wdata   = rng_state;
            cycle();
        end
        imem_we = 1'b0;
    endtask

    `include "tb_if_tests.svh"

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        translate_en = 1'b0;
        tlb_fill     = '0;
        imem_we      = 1'b0;
        imem_waddr   = '0;
        imem_wdata   = '0;
        id_stall     = 1'b0;
        exe_fb       = '0;
        csr_fb       = '0;
        cycle_cnt    = 0;
        err_cnt      = 0;
        rng_state    = SEED;
        last_pc      = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        load_memory();
        sequential_fetch();
        line_crossing();
        redirect_priority();
        wfi_sleep_wake();
        misaligned_target();
        tlb_translation();
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_if_top

//--- src.f
+incdir+.
pcore_pkg.sv
fetch.sv
itlb.sv
imem_line_buf.sv
fwd_stall.sv
if_top.sv
tb_if_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_if_top -f src.f -o tb_if_top

sim_out=$(./obj_dir/tb_if_top || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
